// ==== roadf_stimulus.txt ====
// op addr data expect selects, all hex; selects = rom vram objram snd
// op 0 cpu read, 1 cpu write (expect = irq_n obj_frame snd_irq flip), 2 nvram write,
// 3 nvram read, 4 vblank (data = dip_pause, expect = irq_n), 5 cabinet read, f end
0 4000 12 12 8
0 ffff 34 34 8
0 2000 12 ed 4
0 1000 6b b6 2
0 0000 12 ff 0
0 1580 12 ff 0
0 1500 12 ff 1
1 4000 55 08 0
1 3000 a5 08 0
0 3000 00 a5 0
2 0000 77 00 0
0 3800 00 77 0
1 3812 e1 08 0
3 0012 00 e1 0
2 0812 99 00 0
3 0812 00 e1 0
5 1680 00 00 0
5 1681 00 00 0
5 1682 00 00 0
5 1683 00 00 0
5 1600 00 00 0
1 1480 01 09 0
1 1481 01 0b 0
1 1400 00 0f 0
1 1400 00 0f 0
1 1480 00 0e 0
0 1400 00 ff 0
1 1481 00 08 0
4 0000 01 01 0
1 1487 01 08 0
4 0000 01 00 0
1 1487 00 08 0
1 1487 01 08 0
4 0000 00 01 0
f 0000 00 00 0

// ==== all.f ====
roadf_pkg.sv
roadf_bus_if.sv
roadf_decode.sv
roadf_outlatch.sv
roadf_irq.sv
roadf_work_ram.sv
roadf_cabinet_io.sv
roadf_main.sv
roadf_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module roadf_tb -f all.f -o roadf_sim
	./obj_dir/roadf_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== roadf_tb.sv ====
`default_nettype none

module roadf_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_OPS = 64; // five words per operation in the file

    logic        clk, rst, cpu_cen, rnw, vma;
    logic [15:0] addr;
    logic [7:0]  cpu_dout, cpu_din;
    logic        rom_cs, vram_cs, objram_cs, snd_data_cs;
    logic        flip, snd_irq, obj_frame, irq_n;
    logic [7:0]  rom_data, vram_dout, obj_dout;
    logic [1:0]  start_button, coin_input;
    logic [6:0]  joystick1, joystick2;
    logic        service, dip_pause, lvbl;
    logic [7:0]  dipsw_a, dipsw_b;
    logic [2:0]  dipsw_c;
    logic [15:0] ioctl_addr;
    logic        ioctl_ram, ioctl_wr;
    logic [7:0]  ioctl_dout, ioctl_din;
    logic [15:0] stim [0:5*MAX_OPS-1]; // op, addr, data, expect, selects

    roadf_main #(.RAM_AW(12)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 100 MHz
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run("value check failed");
        end
    endtask

    // one cpu access, four clocks, cen in the second
    task automatic bus_cycle(input logic wr, input logic [15:0] a, input logic [7:0] d,
                             input logic [7:0] exp, input logic [3:0] cs);
        @(posedge clk);
        addr      <= a;
        rnw       <= ~wr;
        vma       <= 1'b1;
        cpu_dout  <= d;
        rom_data  <= d;                // each source gets its own byte
        vram_dout <= ~d;
        obj_dout  <= {d[3:0], d[7:4]}; // nibble swap
        @(posedge clk);
        cpu_cen <= 1'b1;
        @(posedge clk);
        cpu_cen <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare({4'h0, rom_cs, vram_cs, objram_cs, snd_data_cs}, {4'h0, cs}, "chip selects");
        if (wr) begin
            compare({4'h0, irq_n, obj_frame, snd_irq, flip}, exp, "latch outputs");
        end else begin
            compare(cpu_din, exp, "cpu read data");
        end
    endtask

    task automatic nvram_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_dout <= d;
        ioctl_ram  <= 1'b1;
        ioctl_wr   <= 1'b1; // single clock pulse
        @(posedge clk);
        ioctl_wr <= 1'b0;
    endtask

    task automatic nvram_read(input logic [15:0] a, input logic [7:0] exp);
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_ram  <= 1'b1;
        @(posedge clk); // byte is back one clock after the address
        @(negedge clk);
        compare(ioctl_din, exp, "ioctl_din");
    endtask

    // board wiring, 1 on top then joystick bits 6 5 4 2 3 0 1
    function automatic logic [7:0] joy_format(input logic [6:0] j);
        return {1'b1, j[6], j[5], j[4], j[2], j[3], j[0], j[1]};
    endfunction

    task automatic cabinet_read(input logic [15:0] a);
        logic [7:0] exp;
        @(posedge clk);
        start_button <= 2'($urandom());
        coin_input   <= 2'($urandom());
        joystick1    <= 7'($urandom());
        joystick2    <= 7'($urandom());
        service      <= 1'($urandom());
        dipsw_a      <= 8'($urandom());
        dipsw_b      <= 8'($urandom());
        dipsw_c      <= 3'($urandom());
        @(negedge clk);
        if (a[9:7] == 3'd4) begin
            exp = dipsw_b; // in5 port
        end else begin
            case (a[1:0])
                2'd0:    exp = {dipsw_c, start_button, service, coin_input};
                2'd1:    exp = joy_format(joystick1);
                2'd2:    exp = joy_format(joystick2);
                default: exp = dipsw_a;
            endcase
        end
        bus_cycle(1'b0, a, 8'h00, exp, 4'h0);
    endtask

    task automatic vblank_pulse(input logic pause, input logic exp_irq_n);
        int n;
        @(posedge clk);
        dip_pause <= pause;
        lvbl      <= 1'b1;
        @(posedge clk);
        lvbl <= 1'b0; // blanking starts
        @(negedge clk);
        n = 0;
        if (!exp_irq_n) begin
            while (irq_n !== 1'b0) begin
                if (n >= 16) stop_run("timeout, irq_n never went low after vblank");
                @(negedge clk);
                n++;
            end
            compare(8'(n), 8'd1, "irq_n delay in clocks");
        end else begin
            repeat (16) begin
                compare({7'd0, irq_n}, 8'd1, "irq_n with no irq due");
                @(negedge clk);
            end
        end
        @(posedge clk);
        lvbl <= 1'b1;
        @(posedge clk);
        dip_pause <= 1'b1; // only after lvbl is back up, no false edge
    endtask

    initial begin
        int i;
        int ops;
        logic [3:0]  op;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  e;
        logic [3:0]  cs;
        void'($urandom(84));
        rst = 1'b1;
        cpu_cen = 1'b0;
        addr = 16'h0000;
        rnw = 1'b1;
        vma = 1'b0;
        cpu_dout = 8'h00;
        rom_data = 8'h00;
        vram_dout = 8'h00;
        obj_dout = 8'h00;
        start_button = 2'($urandom());
        coin_input = 2'($urandom());
        joystick1 = 7'($urandom());
        joystick2 = 7'($urandom());
        service = 1'($urandom());
        dipsw_a = 8'($urandom());
        dipsw_b = 8'($urandom());
        dipsw_c = 3'($urandom());
        dip_pause = 1'b1; // game running
        lvbl = 1'b1;
        ioctl_addr = 16'h0000;
        ioctl_ram = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_dout = 8'h00;
        for (i = 0; i < 5 * MAX_OPS; i++) stim[i] = 16'h000f; // end marker everywhere
        $readmemh("roadf_stimulus.txt", stim);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare({4'h0, irq_n, obj_frame, snd_irq, flip}, 8'h08, "outputs after reset");
        ops = 0;
        for (i = 0; i < MAX_OPS; i++) begin
            op = stim[5*i][3:0];
            a  = stim[5*i+1];
            d  = stim[5*i+2][7:0];
            e  = stim[5*i+3][7:0];
            cs = stim[5*i+4][3:0];
            if (op == 4'hf) break;
            case (op)
                4'h0:    bus_cycle(1'b0, a, d, e, cs);
                4'h1:    bus_cycle(1'b1, a, d, e, cs);
                4'h2:    nvram_write(a, d);
                4'h3:    nvram_read(a, e);
                4'h4:    vblank_pulse(d[0], e[0]);
                4'h5:    cabinet_read(a);
                default: stop_run("unknown operation code in the stimulus file");
            endcase
            ops++;
        end
        if (ops == 0) begin
            stop_run("no operations read from the stimulus file");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== roadf_main.sv ====
`default_nettype none

module roadf_main #(
    parameter int RAM_AW = 12 // 4 kB work ram
) (
    input  wire        clk,
    input  wire        rst,
    // cpu bus
    input  wire        cpu_cen,
    input  wire [15:0] addr,
    input  wire        rnw,
    input  wire        vma,
    input  wire [7:0]  cpu_dout,
    output logic [7:0] cpu_din,
    // chip selects out to rom, video and sound
    output logic       rom_cs,
    output logic       vram_cs,
    output logic       objram_cs,
    output logic       snd_data_cs,
    output logic       flip,
    output logic       snd_irq,
    output logic       obj_frame,
    output logic       irq_n,
    input  wire [7:0]  rom_data,
    input  wire [7:0]  vram_dout,
    input  wire [7:0]  obj_dout,
    // cabinet
    input  wire [1:0]  start_button,
    input  wire [1:0]  coin_input,
    input  wire [6:0]  joystick1,
    input  wire [6:0]  joystick2,
    input  wire        service,
    input  wire        dip_pause,
    input  wire [7:0]  dipsw_a,
    input  wire [7:0]  dipsw_b,
    input  wire [2:0]  dipsw_c,
    input  wire        lvbl,
    // nvram download
    input  wire [15:0] ioctl_addr,
    input  wire        ioctl_ram,
    input  wire        ioctl_wr,
    input  wire [7:0]  ioctl_dout,
    output logic [7:0] ioctl_din
);

    logic       ram_cs, intst_cs, iow_cs, in5_cs, ior_cs;
    logic       irq_clrn;
    logic [7:0] ram_dout;

    roadf_bus_if bus (.clk(clk));

    // cpu side of the bus, straight from the pins
    assign bus.addr = addr;
    assign bus.rnw  = rnw;
    assign bus.vma  = vma;
    assign bus.dout = cpu_dout;
    assign bus.cen  = cpu_cen;

    roadf_decode u_decode (
        .bus(bus.dev), .rom_cs(rom_cs), .vram_cs(vram_cs), .objram_cs(objram_cs),
        .ram_cs(ram_cs), .intst_cs(intst_cs), .iow_cs(iow_cs),
        .snd_data_cs(snd_data_cs), .in5_cs(in5_cs), .ior_cs(ior_cs)
    );

    roadf_outlatch u_latch (
        .clk(clk), .rst(rst), .bus(bus.dev), .iow_cs(iow_cs), .intst_cs(intst_cs),
        .flip(flip), .snd_irq(snd_irq), .irq_clrn(irq_clrn), .obj_frame(obj_frame)
    );

    roadf_irq u_irq (
        .clk(clk), .rst(rst), .lvbl(lvbl), .dip_pause(dip_pause),
        .irq_clrn(irq_clrn), .irq_n(irq_n)
    );

    roadf_work_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk(clk), .bus(bus.dev), .ram_cs(ram_cs), .ioctl_addr(ioctl_addr),
        .ioctl_ram(ioctl_ram), .ioctl_wr(ioctl_wr), .ioctl_dout(ioctl_dout),
        .ram_dout(ram_dout), .ioctl_din(ioctl_din)
    );

    roadf_cabinet_io u_io (
        .clk(clk), .bus(bus.dev), .rom_cs(rom_cs), .vram_cs(vram_cs),
        .objram_cs(objram_cs), .ram_cs(ram_cs), .ior_cs(ior_cs), .in5_cs(in5_cs),
        .rom_data(rom_data), .vram_dout(vram_dout), .obj_dout(obj_dout),
        .ram_dout(ram_dout), .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .service(service),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c), .cpu_din(cpu_din)
    );

endmodule

`default_nettype wire

// ==== roadf_cabinet_io.sv ====
`default_nettype none

module roadf_cabinet_io (
    input  wire        clk,
    roadf_bus_if.dev   bus,
    input  wire        rom_cs,
    input  wire        vram_cs,
    input  wire        objram_cs,
    input  wire        ram_cs,
    input  wire        ior_cs,
    input  wire        in5_cs,
    input  wire [7:0]  rom_data,
    input  wire [7:0]  vram_dout,
    input  wire [7:0]  obj_dout,
    input  wire [7:0]  ram_dout,
    input  wire [1:0]  start_button,
    input  wire [1:0]  coin_input,
    input  wire [6:0]  joystick1,
    input  wire [6:0]  joystick2,
    input  wire        service,
    input  wire [7:0]  dipsw_a,
    input  wire [7:0]  dipsw_b,
    input  wire [2:0]  dipsw_c, // board jumpers
    output logic [7:0] cpu_din
);

    logic [7:0] cabinet;

    // buttons up top, directions swapped in pairs as wired on the pcb
    function automatic logic [7:0] joy_byte(input logic [6:0] j);
        return {1'b1, j[6:4], j[2], j[3], j[0], j[1]};
    endfunction

    always_comb begin
        case (bus.addr[1:0])
            2'd0:    cabinet = {dipsw_c, start_button, service, coin_input};
            2'd1:    cabinet = joy_byte(joystick1);
            2'd2:    cabinet = joy_byte(joystick2);
            default: cabinet = dipsw_a;
        endcase
    end

    // read mux, one register stage
    always_ff @(posedge clk) begin
        if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (vram_cs) begin
            cpu_din <= vram_dout;
        end else if (ram_cs) begin
            cpu_din <= ram_dout; // already one clock late from the ram
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (ior_cs) begin
            cpu_din <= cabinet;
        end else if (in5_cs) begin
            cpu_din <= dipsw_b;
        end else begin
            cpu_din <= roadf_pkg::unmapped_byte;
        end
    end

endmodule

`default_nettype wire

// ==== roadf_work_ram.sv ====
`default_nettype none

module roadf_work_ram #(
    parameter int RAM_AW = 12
) (
    input  wire        clk,
    roadf_bus_if.dev   bus,
    input  wire        ram_cs,
    input  wire [15:0] ioctl_addr,
    input  wire        ioctl_ram,
    input  wire        ioctl_wr,
    input  wire [7:0]  ioctl_dout,
    output logic [7:0] ram_dout,
    output logic [7:0] ioctl_din
);

    localparam int DEPTH = 2 ** RAM_AW;

    logic [7:0]        mem [DEPTH];
    logic [RAM_AW-1:0] cpu_addr;
    logic              cpu_we;
    logic [RAM_AW-1:0] nv_addr; // download side, top of the ram
    logic              nv_win;
    logic              nv_we;

    assign cpu_addr = bus.addr[RAM_AW-1:0];
    assign cpu_we   = ram_cs && bus.cen && !bus.rnw; // ram_cs carries vma

    // only the first 2 kB of the ram download map onto the nvram
    assign nv_win  = ioctl_ram && (ioctl_addr[15:roadf_pkg::nvram_aw] == '0);
    assign nv_we   = ioctl_wr && nv_win;
    assign nv_addr = {{(RAM_AW - roadf_pkg::nvram_aw){1'b1}},
                      ioctl_addr[roadf_pkg::nvram_aw-1:0]};

    // two ports, both read-before-write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= bus.dout;
        end
        if (nv_we) begin
            mem[nv_addr] <= ioctl_dout;
        end
        ram_dout  <= mem[cpu_addr];
        ioctl_din <= mem[nv_addr]; // save side reads back here
    end

    // the download only runs while the cpu is held, so a clash is a bug
    a_no_clash: assert property (@(posedge clk)
        !(cpu_we && nv_we && (cpu_addr == nv_addr)))
        else $error("work ram: cpu and nvram write same word");

endmodule

`default_nettype wire

// ==== roadf_irq.sv ====
`default_nettype none

module roadf_irq (
    input  wire  clk,
    input  wire  rst,
    input  wire  lvbl,      // low during vertical blank
    input  wire  dip_pause, // low pauses the game
    input  wire  irq_clrn,
    output logic irq_n
);

    logic trig;   // blanking and running
    logic trig_l;

    assign trig = ~lvbl & dip_pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_n  <= 1'b1;
            trig_l <= 1'b0;
        end else begin
            trig_l <= trig;
            if (!irq_clrn) begin
                irq_n <= 1'b1; // clear wins over a new edge
            end else if (trig && !trig_l) begin
                irq_n <= 1'b0; // start of vblank
            end
        end
    end

endmodule

`default_nettype wire

// ==== roadf_outlatch.sv ====
`default_nettype none

module roadf_outlatch (
    input  wire      clk,
    input  wire      rst,
    roadf_bus_if.dev bus,
    input  wire      iow_cs,
    input  wire      intst_cs,
    output logic     flip,
    output logic     snd_irq,
    output logic     irq_clrn,
    output logic     obj_frame
);

    logic intst_l; // intst_cs seen at the last cen edge

    // 259 style latch, A2..A0 picks the bit, D0 is the value
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            snd_irq   <= 1'b0;
            irq_clrn  <= 1'b0; // irq held off until the game enables it
            obj_frame <= 1'b0;
            intst_l   <= 1'b0;
        end else if (bus.cen) begin
            intst_l <= intst_cs;
            // any access flips the buffer, read or write
            if (intst_cs && !intst_l) begin
                obj_frame <= ~obj_frame;
            end
            if (iow_cs && !bus.rnw) begin
                case (bus.addr[2:0])
                    roadf_pkg::latch_flip:     flip     <= bus.dout[0];
                    roadf_pkg::latch_snd_irq:  snd_irq  <= bus.dout[0];
                    roadf_pkg::latch_irq_clrn: irq_clrn <= bus.dout[0];
                    // coin counters and test bit
                    // have nothing to drive here
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== roadf_decode.sv ====
`default_nettype none

module roadf_decode (
    roadf_bus_if.dev bus,
    output logic     rom_cs,
    output logic     vram_cs,
    output logic     objram_cs,
    output logic     ram_cs,
    output logic     intst_cs,
    output logic     iow_cs,
    output logic     snd_data_cs,
    output logic     in5_cs,
    output logic     ior_cs
);

    always_comb begin
        // rom is read only, writes up there hit nothing
        rom_cs      = bus.vma && bus.rnw && (bus.addr >= roadf_pkg::rom_base);
        vram_cs     = 1'b0;
        objram_cs   = 1'b0;
        ram_cs      = 1'b0;
        intst_cs    = 1'b0;
        iow_cs      = 1'b0;
        snd_data_cs = 1'b0;
        in5_cs      = 1'b0;
        ior_cs      = 1'b0;
        if (bus.vma) begin
            case (bus.addr[15:13]) // first 138
                3'd1: begin // 2000-3fff, halves by A12
                    if (bus.addr[12] == roadf_pkg::ram_sel[1]) begin
                        ram_cs = 1'b1; // 3000-3fff
                    end else if (bus.addr[12] == roadf_pkg::vram_sel[1]) begin
                        vram_cs = 1'b1; // 2000-2fff, two chips on the board
                    end
                end
                3'd0: begin
                    case (bus.addr[12:10]) // second 138
                        roadf_pkg::objram_page: objram_cs = 1'b1;
                        roadf_pkg::io_page: begin
                            case (bus.addr[9:7]) // io 138
                                roadf_pkg::io_intst: intst_cs    = 1'b1;
                                roadf_pkg::io_iow:   iow_cs      = 1'b1;
                                roadf_pkg::io_snd:   snd_data_cs = 1'b1;
                                roadf_pkg::io_in5:   in5_cs      = 1'b1;
                                roadf_pkg::io_ior:   ior_cs      = 1'b1;
                                default: ; // 3,6,7 unused
                            endcase
                        end
                        default: ;
                    endcase
                end
                default: ; // rom space handled above
            endcase
        end
    end

    // the three 138 levels never overlap
    a_one_select: assert property (@(posedge bus.clk)
        $onehot0({rom_cs, vram_cs, objram_cs, ram_cs, intst_cs,
                  iow_cs, snd_data_cs, in5_cs, ior_cs}))
        else $error("decode: more than one chip select");

endmodule

`default_nettype wire

// ==== roadf_bus_if.sv ====
`default_nettype none

// cpu side of the main board bus
interface roadf_bus_if (
    input wire clk // only for checks in the devices
);
    logic [15:0] addr;
    logic        rnw;  // 1 = read
    logic        vma;  // valid memory access
    logic [7:0]  dout; // cpu write data
    logic        cen;  // cpu clock enable, qualifies writes

    // driven by the cpu side at the top level
    modport cpu (input clk, output addr, rnw, vma, dout, cen);

    // every decoder, latch and memory just listens
    modport dev (input clk, addr, rnw, vma, dout, cen);

endinterface

`default_nettype wire

// ==== roadf_pkg.sv ====
`default_nettype none

package roadf_pkg;

    // memory map, level one by A15..A13
    localparam logic [15:0] rom_base = 16'h4000; // rom from here to ffff, read only

    // 2000-3fff block, split by A12..A11
    localparam logic [1:0] vram_sel = 2'd0; // 0,1 video ram
    localparam logic [1:0] ram_sel  = 2'd2; // 2,3 work ram, 3 is the nvram half

    // 0000-1fff block, pages by A12..A10
    localparam logic [2:0] objram_page = 3'd4; // 1000-13ff
    localparam logic [2:0] io_page     = 3'd5; // 1400-17ff

    // io ports inside io_page, by A9..A7
    localparam logic [2:0] io_intst = 3'd0; // interrupt status, frame toggle
    localparam logic [2:0] io_iow   = 3'd1; // addressable latch
    localparam logic [2:0] io_snd   = 3'd2; // sound latch
    localparam logic [2:0] io_in5   = 3'd4; // dip bank b
    localparam logic [2:0] io_ior   = 3'd5; // cabinet bytes

    // addressable latch bits, A2..A0
    localparam logic [2:0] latch_flip     = 3'd0;
    localparam logic [2:0] latch_snd_irq  = 3'd1;
    // 2 test out, 3-4 coin counters, 5-6 unused
    localparam logic [2:0] latch_irq_clrn = 3'd7;

    // nvram window, upper half of work ram
    localparam int nvram_aw = 11; // 2 kB

    localparam logic [7:0] unmapped_byte = 8'hff; // open bus pulls up

endpackage

`default_nettype wire
